// ==== compile.f ====
+incdir+source
source/perf_pkg.sv
source/access_counters.sv
source/memory_counters.sv
source/perf_wb_regs.sv
source/cache_perf_monitor.sv
verif/cache_perf_sva.sv
verif/cache_perf_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cache performance monitor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module cache_perf_tb -f compile.f -o cache_perf_sim \
  || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/cache_perf_sim 2>&1)
echo "$sim_out"
echo "$sim_out" | grep -q "PASS: all tests" && echo "simulation passed" && exit 0
echo "simulation failed" && exit 1

// ==== verif/cache_perf_tb.sv ====
`include "perf_defs.svh"

module cache_perf_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import perf_pkg::*;

  localparam int ACK_LIMIT = 20;  // cycles

  logic       clk_i = 1'b0;
  logic       reset_i;
  cache_evt_s cache_evt;
  dma_evt_s   dma_evt;
  fill_evt_s  fill_evt;
  wb_m2s_s    wb_m2s;
  wb_s2m_s    wb_s2m;

  int     seed = 32'h2d81_7c5a;
  count_t exp_acc [0:7];
  count_t exp_mem [0:4];
  count_t fill_cnt;
  logic   bus_busy = 1'b0;  // slave sits in its ack cycle
  logic   clr_pend = 1'b0;  // counters zero at the next edge
  string  names [0:12] = '{"ld_hit", "st_hit", "amo", "miss_ld", "miss_st", "miss_cycles",
                           "stall_rsp", "idle", "dma_rd", "dma_wr", "repl_invalid",
                           "repl_clean", "repl_dirty"};

  cache_perf_monitor UUT (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .cache_evt_i (cache_evt),
    .dma_evt_i   (dma_evt),
    .fill_evt_i  (fill_evt),
    .wb_i        (wb_m2s),
    .wb_o        (wb_s2m)
  );

  always #2 clk_i = ~clk_i;

  // reference model updated at the edges where the DUT samples
  always @(posedge clk_i) begin : model_update
    logic taken;
    logic is_ld;
    logic is_st;
    logic way_valid;
    logic way_dirty;
    taken     = cache_evt.v && cache_evt.yumi;
    is_ld     = (cache_evt.op == op_ld);
    is_st     = (cache_evt.op == op_st);
    way_valid = fill_evt.valid[fill_evt.way];
    way_dirty = fill_evt.dirty[fill_evt.way];
    if (reset_i || clr_pend) begin
      foreach (exp_acc[i]) exp_acc[i] = '0;
      foreach (exp_mem[i]) exp_mem[i] = '0;
      fill_cnt = '0;
    end else begin
      exp_acc[0] += count_t'(taken && is_ld && !cache_evt.miss);
      exp_acc[1] += count_t'(taken && is_st && !cache_evt.miss);
      exp_acc[2] += count_t'(taken && cache_evt.op == op_amo);
      exp_acc[3] += count_t'(taken && is_ld && cache_evt.miss);
      exp_acc[4] += count_t'(taken && is_st && cache_evt.miss);
      exp_acc[5] += count_t'(cache_evt.miss);
      exp_acc[6] += count_t'(cache_evt.v && !cache_evt.yumi);
      exp_acc[7] += count_t'(!cache_evt.v && !cache_evt.miss);
      exp_mem[0] += count_t'(dma_evt.v && dma_evt.yumi && !dma_evt.write);
      exp_mem[1] += count_t'(dma_evt.v && dma_evt.yumi && dma_evt.write);
      exp_mem[2] += count_t'(fill_evt.done && !way_valid);
      exp_mem[3] += count_t'(fill_evt.done && way_valid && !way_dirty);
      exp_mem[4] += count_t'(fill_evt.done && way_valid && way_dirty);
      fill_cnt   += count_t'(fill_evt.done);
    end
    clr_pend = 1'b0;
    if (reset_i || bus_busy) begin
      bus_busy = 1'b0;
    end else if (wb_m2s.cyc && wb_m2s.stb) begin
      bus_busy = 1'b1;
      clr_pend = wb_m2s.we && wb_m2s.dat[0] && (int'(wb_m2s.adr) == `PERF_ADR_CTRL);
    end
  end

  function automatic count_t model_value(input wb_adr_t adr);
    int a;
    int off;
    a   = int'(adr);
    off = a - `PERF_ADR_MEM_BASE;
    if (a < `PERF_NUM_ACC) begin
      return exp_acc[a[2:0]];
    end else if (off >= 0 && off < `PERF_NUM_MEM) begin
      return exp_mem[off[2:0]];
    end
    return '0;  // control and unmapped words
  endfunction

  function automatic string reg_label(input wb_adr_t adr);
    int a;
    a = int'(adr);
    if (a < 13) begin
      return names[a[3:0]];
    end
    if (a == `PERF_ADR_CTRL) begin
      return "ctrl";
    end
    return "unmapped";
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_ack();
    int waited;
    waited = 0;
    do begin
      next_cycle();
      waited++;
      if (waited > ACK_LIMIT) begin
        abort_run($sformatf("bus slave gave no ack within %0d cycles, at %0t ns",
                            ACK_LIMIT, $time));
      end
    end while (!wb_s2m.ack);
    wb_m2s.cyc = 1'b0;
    wb_m2s.stb = 1'b0;
    wb_m2s.we  = 1'b0;
  endtask

  task automatic wb_read(input wb_adr_t adr, output wb_dat_t dat);
    wb_m2s = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
    wait_ack();
    dat = wb_s2m.dat;
    next_cycle();  // stb low for one edge between transfers
  endtask

  task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat);
    wb_m2s = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    wait_ack();
    next_cycle();
  endtask

  task automatic read_check(input wb_adr_t adr, output count_t got);
    count_t  exp;
    wb_dat_t dat;
    exp = model_value(adr);  // counter as it stands at the sampling edge
    wb_read(adr, dat);
    got = dat;
    assert (got == exp) else begin
      abort_run($sformatf("[FAIL] %0t ns %s: read %0d, expected %0d",
                          $time, reg_label(adr), got, exp));
    end
  endtask

  task automatic drive_cache_random(input int cycles);
    logic [31:0] r;
    repeat (cycles) begin
      r = $random(seed);
      cache_evt.v    = r[0];
      cache_evt.yumi = r[1];
      cache_evt.miss = r[2];
      cache_evt.op   = cache_op_e'(r[4:3]);
      next_cycle();
    end
  endtask

  task automatic drive_mem_random(input int cycles);
    logic [31:0] r;
    repeat (cycles) begin
      r = $random(seed);
      dma_evt.v      = r[0];
      dma_evt.yumi   = r[1];
      dma_evt.write  = r[2];
      fill_evt.done  = r[3];
      fill_evt.way   = r[5:4];
      fill_evt.valid = r[9:6];
      fill_evt.dirty = r[13:10];
      next_cycle();
    end
  endtask

  task automatic quiet_inputs();
    cache_evt = '0;
    dma_evt   = '0;
    fill_evt  = '0;
  endtask

  initial begin : main
    count_t got;
    count_t repl_sum;
    reset_i = 1'b1;
    wb_m2s  = '0;
    quiet_inputs();
    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    next_cycle();

    for (int a = 0; a <= 13; a++) read_check(wb_adr_t'(a), got);
    read_check(wb_adr_t'(`PERF_ADR_CTRL), got);

    drive_cache_random(300);
    quiet_inputs();
    for (int a = 0; a < `PERF_NUM_ACC; a++) read_check(wb_adr_t'(a), got);

    drive_mem_random(200);
    quiet_inputs();
    repl_sum = '0;
    for (int a = 0; a < `PERF_NUM_MEM; a++) begin
      read_check(wb_adr_t'(`PERF_ADR_MEM_BASE + a), got);
      if (a >= 2) begin
        repl_sum += got;
      end
    end
    assert (repl_sum == fill_cnt) else begin
      abort_run($sformatf("[FAIL] %0t ns repl_sum: read %0d, expected %0d",
                          $time, repl_sum, fill_cnt));
    end

    // clear then a write elsewhere that must be ignored
    wb_write(wb_adr_t'(`PERF_ADR_CTRL), 32'd1);
    wb_write(wb_adr_t'(3), 32'd1);
    for (int a = 0; a < 13; a++) read_check(wb_adr_t'(a), got);

    fork
      drive_cache_random(150);
      for (int n = 0; n < 60; n++) read_check(wb_adr_t'(n % 8), got);
    join
    quiet_inputs();
    for (int a = 0; a < 13; a++) read_check(wb_adr_t'(a), got);

    if (UUT.u_bus_checks.fail_cnt == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      abort_run("bus protocol assertions reported errors");
    end
  end

endmodule

// ==== verif/cache_perf_sva.sv ====
module cache_perf_sva (
  input logic              clk_i,
  input logic              reset_i,
  input perf_pkg::wb_m2s_s wb_m2s_i,
  input perf_pkg::wb_s2m_s wb_s2m_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;  // failed bus assertions so far
  logic        req;

  assign req = wb_m2s_i.cyc && wb_m2s_i.stb;

  // synchronous reset forces idle so ack is low one edge later
  ack_low_in_reset: assert property (@(posedge clk_i) reset_i |=> !wb_s2m_i.ack)
    else begin
      $error("ack high after a reset cycle");
      fail_cnt++;
    end

  ack_needs_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_s2m_i.ack |-> $past(req))
    else begin
      $error("ack without cyc and stb on the cycle before");
      fail_cnt++;
    end

  ack_single_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_s2m_i.ack |=> !wb_s2m_i.ack)
    else begin
      $error("ack high for two cycles in a row");
      fail_cnt++;
    end

  ack_after_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
    $rose(req) |=> wb_s2m_i.ack)
    else begin
      $error("no ack one cycle after a new strobe");
      fail_cnt++;
    end

endmodule

bind cache_perf_monitor cache_perf_sva u_bus_checks (
  .clk_i    (clk_i),
  .reset_i  (reset_i),
  .wb_m2s_i (wb_i),
  .wb_s2m_i (wb_o)
);

// ==== source/cache_perf_monitor.sv ====
module cache_perf_monitor (
  input  logic                clk_i,
  input  logic                reset_i,
  input  perf_pkg::cache_evt_s cache_evt_i,
  input  perf_pkg::dma_evt_s   dma_evt_i,
  input  perf_pkg::fill_evt_s  fill_evt_i,
  input  perf_pkg::wb_m2s_s    wb_i,
  output perf_pkg::wb_s2m_s    wb_o
);

  import perf_pkg::*;

  acc_counts_s acc_counts;
  mem_counts_s mem_counts;
  logic        clr;         // counter clear from control write

  access_counters u_access_counters (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .clr_i    (clr),
    .evt_i    (cache_evt_i),
    .counts_o (acc_counts)
  );

  memory_counters u_memory_counters (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .clr_i    (clr),
    .dma_i    (dma_evt_i),
    .fill_i   (fill_evt_i),
    .counts_o (mem_counts)
  );

  perf_wb_regs u_perf_wb_regs (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .wb_i    (wb_i),
    .acc_i   (acc_counts),
    .mem_i   (mem_counts),
    .wb_o    (wb_o),
    .clr_o   (clr)
  );

endmodule

// ==== source/perf_wb_regs.sv ====
`include "perf_defs.svh"

module perf_wb_regs (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  perf_pkg::wb_m2s_s     wb_i,
  input  perf_pkg::acc_counts_s acc_i,
  input  perf_pkg::mem_counts_s mem_i,
  output perf_pkg::wb_s2m_s     wb_o,
  output logic                  clr_o
);

  import perf_pkg::*;

  localparam int ACC_IDX_W = $clog2(`PERF_NUM_ACC);
  localparam int MEM_IDX_W = $clog2(`PERF_NUM_MEM);

  // counters as word arrays with index 0 the first struct field
  count_t [0:`PERF_NUM_ACC-1] acc_words;
  count_t [0:`PERF_NUM_MEM-1] mem_words;

  wb_state_e state_q;
  wb_dat_t   rd_dat_q;
  wb_dat_t   rd_mux;
  wb_adr_t   mem_off;   // address relative to memory block
  logic      req;       // new transfer seen in idle
  logic      clr_wr;
  logic      clr_q;

  assign acc_words = acc_i;
  assign mem_words = mem_i;
  assign mem_off   = wb_i.adr - wb_adr_t'(`PERF_ADR_MEM_BASE);

  assign req    = (state_q == wb_idle) && wb_i.cyc && wb_i.stb;
  assign clr_wr = wb_i.we && (wb_i.adr == wb_adr_t'(`PERF_ADR_CTRL)) && wb_i.dat[0];

  // control register and unmapped addresses read as zero
  always_comb begin
    rd_mux = '0;
    if (wb_i.adr < wb_adr_t'(`PERF_NUM_ACC)) begin
      rd_mux = wb_dat_t'(acc_words[wb_i.adr[ACC_IDX_W-1:0]]);
    end else if (mem_off < wb_adr_t'(`PERF_NUM_MEM)) begin
      rd_mux = wb_dat_t'(mem_words[mem_off[MEM_IDX_W-1:0]]);
    end
  end

  // ack state lasts one cycle and idle then ignores the lingering stb
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= wb_idle;
      clr_q   <= 1'b0;
    end else begin
      clr_q <= 1'b0;
      case (state_q)
        wb_idle: begin
          if (req) begin
            state_q <= wb_ack;
            clr_q   <= clr_wr;
          end
        end
        default: begin
          state_q <= wb_idle;
        end
      endcase
    end
  end

  // snapshot taken at the sampling edge
  always_ff @(posedge clk_i) begin
    if (req) begin
      rd_dat_q <= rd_mux;
    end
  end

  assign wb_o.ack = (state_q == wb_ack);
  assign wb_o.dat = rd_dat_q;
  assign clr_o    = clr_q;

endmodule

// ==== source/memory_counters.sv ====
module memory_counters (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  clr_i,
  input  perf_pkg::dma_evt_s    dma_i,
  input  perf_pkg::fill_evt_s   fill_i,
  output perf_pkg::mem_counts_s counts_o
);

  import perf_pkg::*;

  logic dma_take;       // request accepted by memory side
  logic dma_rd_inc;
  logic dma_wr_inc;
  logic victim_valid;
  logic victim_dirty;
  logic repl_inv_inc;
  logic repl_cln_inc;
  logic repl_drt_inc;

  assign dma_take   = dma_i.v & dma_i.yumi;
  assign dma_rd_inc = dma_take & ~dma_i.write;
  assign dma_wr_inc = dma_take & dma_i.write;

  // state of the way being replaced before the fill lands
  assign victim_valid = fill_i.valid[fill_i.way];
  assign victim_dirty = fill_i.dirty[fill_i.way];

  // exactly one of these rises per completed fill
  assign repl_inv_inc = fill_i.done & ~victim_valid;
  assign repl_cln_inc = fill_i.done & victim_valid & ~victim_dirty;
  assign repl_drt_inc = fill_i.done & victim_valid & victim_dirty;

  always_ff @(posedge clk_i) begin
    if (reset_i || clr_i) begin
      counts_o <= '0;
    end else begin
      if (dma_rd_inc) begin
        counts_o.dma_rd <= counts_o.dma_rd + 1'b1;
      end
      if (dma_wr_inc) begin
        counts_o.dma_wr <= counts_o.dma_wr + 1'b1;
      end
      if (repl_inv_inc) begin
        counts_o.repl_invalid <= counts_o.repl_invalid + 1'b1;
      end
      if (repl_cln_inc) begin
        counts_o.repl_clean <= counts_o.repl_clean + 1'b1;
      end
      if (repl_drt_inc) begin
        counts_o.repl_dirty <= counts_o.repl_dirty + 1'b1;
      end
    end
  end

endmodule

// ==== source/access_counters.sv ====
module access_counters (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  clr_i,     // one-cycle clear from bus slave
  input  perf_pkg::cache_evt_s  evt_i,
  output perf_pkg::acc_counts_s counts_o
);

  import perf_pkg::*;

  logic taken;        // response handed to consumer this cycle
  logic is_ld;
  logic is_st;
  logic ld_hit_inc;
  logic st_hit_inc;
  logic amo_inc;
  logic miss_ld_inc;
  logic miss_st_inc;
  logic miss_cyc_inc;
  logic stall_inc;
  logic idle_inc;

  assign taken = evt_i.v & evt_i.yumi;
  assign is_ld = (evt_i.op == op_ld);
  assign is_st = (evt_i.op == op_st);

  assign ld_hit_inc   = taken & is_ld & ~evt_i.miss;
  assign st_hit_inc   = taken & is_st & ~evt_i.miss;
  assign amo_inc      = taken & (evt_i.op == op_amo);  // hit or miss alike
  assign miss_ld_inc  = taken & is_ld & evt_i.miss;
  assign miss_st_inc  = taken & is_st & evt_i.miss;
  assign miss_cyc_inc = evt_i.miss;                     // handler busy cycles
  assign stall_inc    = evt_i.v & ~evt_i.yumi;          // consumer back-pressure
  assign idle_inc     = ~evt_i.v & ~evt_i.miss;

  // clear has priority over any increment in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i || clr_i) begin
      counts_o <= '0;
    end else begin
      if (ld_hit_inc) begin
        counts_o.ld_hit <= counts_o.ld_hit + 1'b1;
      end
      if (st_hit_inc) begin
        counts_o.st_hit <= counts_o.st_hit + 1'b1;
      end
      if (amo_inc) begin
        counts_o.amo <= counts_o.amo + 1'b1;
      end
      if (miss_ld_inc) begin
        counts_o.miss_ld <= counts_o.miss_ld + 1'b1;
      end
      if (miss_st_inc) begin
        counts_o.miss_st <= counts_o.miss_st + 1'b1;
      end
      if (miss_cyc_inc) begin
        counts_o.miss_cycles <= counts_o.miss_cycles + 1'b1;
      end
      if (stall_inc) begin
        counts_o.stall_rsp <= counts_o.stall_rsp + 1'b1;
      end
      if (idle_inc) begin
        counts_o.idle <= counts_o.idle + 1'b1;
      end
    end
  end

endmodule

// ==== source/perf_pkg.sv ====
`include "perf_defs.svh"

package perf_pkg;

  typedef logic [`PERF_CNT_W-1:0]         count_t;
  typedef logic [$clog2(`PERF_WAYS)-1:0]  way_idx_t;
  typedef logic [`PERF_WAYS-1:0]          way_mask_t;
  typedef logic [`PERF_ADR_W-1:0]         wb_adr_t;
  typedef logic [31:0]                    wb_dat_t;

  // operation held in the response stage
  typedef enum logic [1:0] {
    op_ld    = 2'b00,
    op_st    = 2'b01,
    op_amo   = 2'b10,
    op_other = 2'b11  // tag, flush, invalidate, lock
  } cache_op_e;

  typedef enum logic {
    wb_idle = 1'b0,
    wb_ack  = 1'b1
  } wb_state_e;

  typedef struct packed {
    logic      v;     // response valid
    logic      yumi;  // response taken by consumer
    logic      miss;  // miss handler busy
    cache_op_e op;
  } cache_evt_s;

  typedef struct packed {
    logic v;
    logic yumi;
    logic write;  // write, not read
  } dma_evt_s;

  typedef struct packed {
    logic      done;   // fill address sent and dma done
    way_idx_t  way;    // victim way
    way_mask_t valid;
    way_mask_t dirty;
  } fill_evt_s;

  typedef struct packed {
    count_t ld_hit;
    count_t st_hit;
    count_t amo;
    count_t miss_ld;
    count_t miss_st;
    count_t miss_cycles;
    count_t stall_rsp;
    count_t idle;
  } acc_counts_s;

  typedef struct packed {
    count_t dma_rd;
    count_t dma_wr;
    count_t repl_invalid;
    count_t repl_clean;
    count_t repl_dirty;
  } mem_counts_s;

  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    wb_dat_t dat;
  } wb_m2s_s;

  typedef struct packed {
    logic    ack;
    wb_dat_t dat;
  } wb_s2m_s;

endpackage

// ==== source/perf_defs.svh ====
`ifndef PERF_DEFS_SVH
`define PERF_DEFS_SVH

// counter and cache geometry
`define PERF_CNT_W 32       // counters wrap at this width
`define PERF_WAYS 4         // cache associativity

// wishbone word addressing
`define PERF_ADR_W 5

// register map
`define PERF_NUM_ACC 8      // request counters at 0..7
`define PERF_NUM_MEM 5      // memory counters follow
`define PERF_ADR_MEM_BASE 8
`define PERF_ADR_CTRL 16    // bit 0 clears every counter

`endif
